//--- ising_pkg.sv
////////////////////
// shared defaults and enum types for the ising solver core
// referenced by scoped names, the top level passes the
// parameter values down to every block
////////////////////

package ising_pkg;

    ////////////////////
    // default sizes
    ////////////////////
    localparam int DEFAULT_NUM_SPIN   = 8;  // spins, also rows of J
    localparam int DEFAULT_BIT_J      = 4;  // signed coupling width
    localparam int DEFAULT_FLIP_DEPTH = 4;  // flip mask words, power of two

    localparam int SWEEP_W = 8;             // sweep count width

    ////////////////////
    // host write target
    ////////////////////
    typedef enum logic {
        SEL_J    = 1'b0,    // one row of the coupling matrix
        SEL_FLIP = 1'b1     // one flip mask word
    } mem_sel_e;

    ////////////////////
    // spin engine states
    ////////////////////
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        FLIP_RD    = 3'd1,  // fetch flip mask of this sweep
        FLIP_APPLY = 3'd2,  // xor mask into the spins
        ROW_RD     = 3'd3,  // fetch J row of the current spin
        ROW_UPDATE = 3'd4,  // field sum and sign write back
        FINISH     = 3'd5
    } engine_state_e;

endpackage

//--- ising_host_port.sv
////////////////////
// host side of the ising core
// turns plain write strobes into J / flip memory writes and
// latches sweep count and initial spins on start
// everything from the host is dropped while the engine is busy
////////////////////

`timescale 1ns/1ns

module ising_host_port #(
    parameter int  NUM_SPIN = ising_pkg::DEFAULT_NUM_SPIN,
    parameter int  BIT_J    = ising_pkg::DEFAULT_BIT_J,
    localparam int ADDR_W   = $clog2(NUM_SPIN)
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    // host writes
    input  logic                         wr_en_i,
    input  ising_pkg::mem_sel_e          wr_sel_i,
    input  logic [ADDR_W-1:0]            wr_addr_i,
    input  logic [NUM_SPIN*BIT_J-1:0]    wr_data_i,
    // run request
    input  logic                         start_i,
    input  logic [ising_pkg::SWEEP_W-1:0] sweeps_i,
    input  logic [NUM_SPIN-1:0]          init_spins_i,
    input  logic                         busy_i,
    // memory write side
    output logic                         j_we_o,
    output logic                         flip_we_o,
    output logic [ADDR_W-1:0]            mem_addr_o,
    output logic [NUM_SPIN*BIT_J-1:0]    mem_data_o,
    // engine side
    output logic                         run_o,
    output logic [ising_pkg::SWEEP_W-1:0] run_sweeps_o,
    output logic [NUM_SPIN-1:0]          run_spins_o
);

    logic wr_ok;
    logic start_ok;

    assign wr_ok    = wr_en_i & ~busy_i;
    assign start_ok = start_i & ~busy_i;

    // write decode, lands in the memory at the next edge
    assign j_we_o     = wr_ok & (wr_sel_i == ising_pkg::SEL_J);
    assign flip_we_o  = wr_ok & (wr_sel_i == ising_pkg::SEL_FLIP);
    assign mem_addr_o = wr_addr_i;
    assign mem_data_o = wr_data_i;  // flip masks only use the low bits

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run_o <= 1'b0;
        end else begin
            run_o <= start_ok;  // one cycle pulse
        end
    end

    // run configuration, held until the next accepted start
    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            run_sweeps_o <= sweeps_i;
            run_spins_o  <= init_spins_i;
        end
    end

endmodule

//--- ising_coupling_mem.sv
////////////////////
// small register array with one write port and one read port
// read data appears the cycle after ren_i
// used for the J rows and for the flip mask table
////////////////////

`timescale 1ns/1ns

module ising_coupling_mem #(
    parameter int  WIDTH  = 32,
    parameter int  DEPTH  = 8,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk_i,
    // write port
    input  logic              we_i,
    input  logic [ADDR_W-1:0] waddr_i,
    input  logic [WIDTH-1:0]  wdata_i,
    // read port
    input  logic              ren_i,
    input  logic [ADDR_W-1:0] raddr_i,
    output logic [WIDTH-1:0]  rdata_o
);

    logic [WIDTH-1:0] mem_q [DEPTH];

    ////////////////////
    // write
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    ////////////////////
    // registered read
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (ren_i) begin
            rdata_o <= mem_q[raddr_i];  // holds last word when idle
        end
    end

endmodule

//--- ising_spin_engine.sv
////////////////////
// sweep engine of the ising core
// per sweep: fetch and xor one flip mask, then visit every spin
// in index order, fetch its J row, sum J[i][j]*s_j and keep the sign
// spin bit 1 is +1, bit 0 is -1, a zero field gives +1
////////////////////

`timescale 1ns/1ns

module ising_spin_engine #(
    parameter int  NUM_SPIN   = ising_pkg::DEFAULT_NUM_SPIN,
    parameter int  BIT_J      = ising_pkg::DEFAULT_BIT_J,
    parameter int  FLIP_DEPTH = ising_pkg::DEFAULT_FLIP_DEPTH,
    localparam int IDX_W      = $clog2(NUM_SPIN),
    localparam int FLIP_AW    = $clog2(FLIP_DEPTH)
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          run_i,
    input  logic [ising_pkg::SWEEP_W-1:0] run_sweeps_i,
    input  logic [NUM_SPIN-1:0]           run_spins_i,
    // J memory
    output logic                          j_ren_o,
    output logic [IDX_W-1:0]              j_raddr_o,
    input  logic [NUM_SPIN*BIT_J-1:0]     j_rdata_i,
    // flip memory
    output logic                          flip_ren_o,
    output logic [FLIP_AW-1:0]            flip_raddr_o,
    input  logic [NUM_SPIN-1:0]           flip_rdata_i,
    // status
    output logic [NUM_SPIN-1:0]           spins_o,
    output logic                          busy_o,
    output logic                          finish_o
);

    // wide enough for NUM_SPIN terms of magnitude 2^(BIT_J-1)
    localparam int SUM_W = BIT_J + $clog2(NUM_SPIN) + 1;

    ising_pkg::engine_state_e state_q, state_d;

    logic [ising_pkg::SWEEP_W-1:0] sweep_q;   // sweeps done so far
    logic [IDX_W-1:0]              idx_q;     // spin being updated
    logic [NUM_SPIN-1:0]           spins_q;
    logic                          last_spin;
    logic                          last_sweep;

    logic signed [BIT_J-1:0]       j_val;
    logic signed [SUM_W-1:0]       field;

    assign last_spin  = (idx_q == IDX_W'(NUM_SPIN - 1));
    assign last_sweep = (sweep_q + 1'b1 == run_sweeps_i);

    ////////////////////
    // local field of spin idx_q
    ////////////////////
    // row layout: J[i][j] sits at bits j*BIT_J +: BIT_J
    always_comb begin
        field = '0;
        j_val = '0;
        for (int j = 0; j < NUM_SPIN; j++) begin
            j_val = $signed(j_rdata_i[j*BIT_J +: BIT_J]);
            if (spins_q[j]) begin
                field = field + SUM_W'(j_val);
            end else begin
                field = field - SUM_W'(j_val);
            end
        end
    end

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ising_pkg::IDLE: begin
                if (run_i) begin
                    state_d = (run_sweeps_i == '0) ? ising_pkg::FINISH : ising_pkg::FLIP_RD;
                end
            end
            ising_pkg::FLIP_RD:    state_d = ising_pkg::FLIP_APPLY;
            ising_pkg::FLIP_APPLY: state_d = ising_pkg::ROW_RD;
            ising_pkg::ROW_RD:     state_d = ising_pkg::ROW_UPDATE;
            ising_pkg::ROW_UPDATE: begin
                if (!last_spin) begin
                    state_d = ising_pkg::ROW_RD;
                end else if (last_sweep) begin
                    state_d = ising_pkg::FINISH;
                end else begin
                    state_d = ising_pkg::FLIP_RD;
                end
            end
            ising_pkg::FINISH:     state_d = ising_pkg::IDLE;
            default:               state_d = ising_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ising_pkg::IDLE;
            sweep_q <= '0;
            idx_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ising_pkg::IDLE && run_i) begin
                sweep_q <= '0;
                idx_q   <= '0;
            end else if (state_q == ising_pkg::ROW_UPDATE) begin
                idx_q <= last_spin ? '0 : idx_q + 1'b1;
                if (last_spin) begin
                    sweep_q <= sweep_q + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // spin vector
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (state_q == ising_pkg::IDLE && run_i) begin
            spins_q <= run_spins_i;
        end else if (state_q == ising_pkg::FLIP_APPLY) begin
            spins_q <= spins_q ^ flip_rdata_i;
        end else if (state_q == ising_pkg::ROW_UPDATE) begin
            spins_q[idx_q] <= ~field[SUM_W-1];  // sign bit clear -> +1
        end
    end

    // memory reads, data used one cycle later
    assign j_ren_o      = (state_q == ising_pkg::ROW_RD);
    assign j_raddr_o    = idx_q;
    assign flip_ren_o   = (state_q == ising_pkg::FLIP_RD);
    assign flip_raddr_o = sweep_q[FLIP_AW-1:0];  // sweep k mod FLIP_DEPTH

    assign spins_o  = spins_q;
    assign finish_o = (state_q == ising_pkg::FINISH);
    assign busy_o   = (state_q != ising_pkg::IDLE) | run_i;  // covers the run cycle

endmodule

//--- ising_readout.sv
////////////////////
// result side of the ising core
// captures the spins and their +1 count when the engine finishes
// and keeps them until the next run
////////////////////

`timescale 1ns/1ns

module ising_readout #(
    parameter int  NUM_SPIN = ising_pkg::DEFAULT_NUM_SPIN,
    localparam int CNT_W    = $clog2(NUM_SPIN + 1)
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                run_i,
    input  logic                finish_i,
    input  logic [NUM_SPIN-1:0] spins_i,
    output logic [NUM_SPIN-1:0] spins_o,
    output logic [CNT_W-1:0]    magnet_o,
    output logic                done_o,
    output logic                result_valid_o
);

    logic [CNT_W-1:0] pop_cnt;

    // number of +1 spins
    always_comb begin
        pop_cnt = '0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            pop_cnt = pop_cnt + CNT_W'(spins_i[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (finish_i) begin
            spins_o  <= spins_i;
            magnet_o <= pop_cnt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_o         <= 1'b0;
            result_valid_o <= 1'b0;
        end else begin
            done_o <= finish_i;     // lines up with the captured result
            if (finish_i) begin
                result_valid_o <= 1'b1;
            end else if (run_i) begin
                result_valid_o <= 1'b0;
            end
        end
    end

endmodule

//--- ising_core.sv
////////////////////
// top level of the digital ising solver core
// host writes J rows and flip masks, then pulses start with a
// sweep count and initial spins, result comes back with done_o
// flip depth must not exceed NUM_SPIN, both share one write address
////////////////////

`timescale 1ns/1ns

module ising_core #(
    parameter int  NUM_SPIN   = ising_pkg::DEFAULT_NUM_SPIN,
    parameter int  BIT_J      = ising_pkg::DEFAULT_BIT_J,
    parameter int  FLIP_DEPTH = ising_pkg::DEFAULT_FLIP_DEPTH,
    localparam int ADDR_W     = $clog2(NUM_SPIN),
    localparam int FLIP_AW    = $clog2(FLIP_DEPTH),
    localparam int CNT_W      = $clog2(NUM_SPIN + 1)
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          wr_en_i,
    input  ising_pkg::mem_sel_e           wr_sel_i,
    input  logic [ADDR_W-1:0]             wr_addr_i,
    input  logic [NUM_SPIN*BIT_J-1:0]     wr_data_i,
    input  logic                          start_i,
    input  logic [ising_pkg::SWEEP_W-1:0] sweeps_i,
    input  logic [NUM_SPIN-1:0]           init_spins_i,
    output logic                          busy_o,
    output logic                          done_o,
    output logic                          result_valid_o,
    output logic [NUM_SPIN-1:0]           spins_o,
    output logic [CNT_W-1:0]              magnet_o
);

    logic                          j_we, flip_we, run, finish;
    logic [ADDR_W-1:0]             mem_addr;
    logic [NUM_SPIN*BIT_J-1:0]     mem_data, j_rdata;
    logic [ising_pkg::SWEEP_W-1:0] run_sweeps;
    logic [NUM_SPIN-1:0]           run_spins, flip_rdata, spins;
    logic                          j_ren, flip_ren;
    logic [ADDR_W-1:0]             j_raddr;
    logic [FLIP_AW-1:0]            flip_raddr;

    ////////////////////
    // input side
    ////////////////////
    ising_host_port #(.NUM_SPIN(NUM_SPIN), .BIT_J(BIT_J)) u_host_port (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .wr_en_i      (wr_en_i),
        .wr_sel_i     (wr_sel_i),
        .wr_addr_i    (wr_addr_i),
        .wr_data_i    (wr_data_i),
        .start_i      (start_i),
        .sweeps_i     (sweeps_i),
        .init_spins_i (init_spins_i),
        .busy_i       (busy_o),
        .j_we_o       (j_we),
        .flip_we_o    (flip_we),
        .mem_addr_o   (mem_addr),
        .mem_data_o   (mem_data),
        .run_o        (run),
        .run_sweeps_o (run_sweeps),
        .run_spins_o  (run_spins)
    );

    ////////////////////
    // memories and engine
    ////////////////////
    ising_coupling_mem #(.WIDTH(NUM_SPIN*BIT_J), .DEPTH(NUM_SPIN)) u_j_mem (
        .clk_i   (clk_i),
        .we_i    (j_we),
        .waddr_i (mem_addr),
        .wdata_i (mem_data),
        .ren_i   (j_ren),
        .raddr_i (j_raddr),
        .rdata_o (j_rdata)
    );

    ising_coupling_mem #(.WIDTH(NUM_SPIN), .DEPTH(FLIP_DEPTH)) u_flip_mem (
        .clk_i   (clk_i),
        .we_i    (flip_we),
        .waddr_i (mem_addr[FLIP_AW-1:0]),
        .wdata_i (mem_data[NUM_SPIN-1:0]),  // mask in the low bits
        .ren_i   (flip_ren),
        .raddr_i (flip_raddr),
        .rdata_o (flip_rdata)
    );

    ising_spin_engine #(
        .NUM_SPIN   (NUM_SPIN),
        .BIT_J      (BIT_J),
        .FLIP_DEPTH (FLIP_DEPTH)
    ) u_spin_engine (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .run_i        (run),
        .run_sweeps_i (run_sweeps),
        .run_spins_i  (run_spins),
        .j_ren_o      (j_ren),
        .j_raddr_o    (j_raddr),
        .j_rdata_i    (j_rdata),
        .flip_ren_o   (flip_ren),
        .flip_raddr_o (flip_raddr),
        .flip_rdata_i (flip_rdata),
        .spins_o      (spins),
        .busy_o       (busy_o),
        .finish_o     (finish)
    );

    ////////////////////
    // output side
    ////////////////////
    ising_readout #(.NUM_SPIN(NUM_SPIN)) u_readout (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .run_i          (run),
        .finish_i       (finish),
        .spins_i        (spins),
        .spins_o        (spins_o),
        .magnet_o       (magnet_o),
        .done_o         (done_o),
        .result_valid_o (result_valid_o)
    );

endmodule

//--- tb_clock_gen.sv
////////////////////
// clock and reset source for the ising core testbench
// free running clock, reset held high for the first cycles
////////////////////

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;    // released just after the edge like other inputs
    end

endmodule

//--- ising_core_asserts.sv
////////////////////
// concurrent checks on the ising core outputs
// reset state, exact done timing, busy window, result hold and clear
// attached to every ising_core instance by the bind at the bottom
////////////////////

`timescale 1ns/1ns

module ising_core_asserts #(
    parameter int  NUM_SPIN = ising_pkg::DEFAULT_NUM_SPIN,
    localparam int CNT_W    = $clog2(NUM_SPIN + 1)
) (
    input logic                          clk_i,
    input logic                          rst_i,
    input logic                          start_i,
    input logic [ising_pkg::SWEEP_W-1:0] sweeps_i,
    input logic                          run_i,
    input logic                          busy_i,
    input logic                          done_i,
    input logic                          result_valid_i,
    input logic [NUM_SPIN-1:0]           spins_i,
    input logic [CNT_W-1:0]              magnet_i
);

    logic        assert_fail = 1'b0;    // sticky, set by any failing property
    logic        armed_q;               // accepted start, done not yet seen
    logic [15:0] wait_q;                // edges left until done_o

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            armed_q <= 1'b0;
            wait_q  <= 16'd0;
        end else if (start_i && !busy_i) begin
            armed_q <= 1'b1;
            wait_q  <= 16'(sweeps_i) * 16'(2 * NUM_SPIN + 2) + 16'd2;
        end else begin
            if (wait_q != 16'd0) begin
                wait_q <= wait_q - 16'd1;
            end
            if (done_i) begin
                armed_q <= 1'b0;
            end
        end
    end

    ////////////////////
    // properties
    ////////////////////
    a_reset_idle: assert property (@(posedge clk_i)
        rst_i |=> !busy_i && !done_i && !result_valid_i)
        else begin
            assert_fail = 1'b1;
            $error("outputs not idle after reset");
        end

    a_done_exact: assert property (@(posedge clk_i) disable iff (rst_i)
        done_i |-> armed_q && wait_q == 16'd0)
        else begin
            assert_fail = 1'b1;
            $error("done_o came early or unrequested");
        end

    a_done_late: assert property (@(posedge clk_i) disable iff (rst_i)
        armed_q && wait_q == 16'd0 |-> done_i)
        else begin
            assert_fail = 1'b1;
            $error("done_o missing at the expected cycle");
        end

    a_busy_held: assert property (@(posedge clk_i) disable iff (rst_i)
        armed_q && wait_q != 16'd0 |-> busy_i)
        else begin
            assert_fail = 1'b1;
            $error("busy_o dropped before done_o");
        end

    a_busy_drop: assert property (@(posedge clk_i) disable iff (rst_i)
        done_i |-> !busy_i && result_valid_i)
        else begin
            assert_fail = 1'b1;
            $error("busy_o or result_valid_o wrong at done_o");
        end

    // result stays put until the next run pulse
    a_result_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_i && !run_i |=> result_valid_i && $stable(spins_i) && $stable(magnet_i))
        else begin
            assert_fail = 1'b1;
            $error("result changed while result_valid_o high");
        end

    // a new run withdraws the old result
    a_result_clear: assert property (@(posedge clk_i) disable iff (rst_i)
        run_i |=> !result_valid_i)
        else begin
            assert_fail = 1'b1;
            $error("result_valid_o still high after a new start");
        end

endmodule

bind ising_core ising_core_asserts #(.NUM_SPIN(NUM_SPIN)) u_asserts (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .start_i        (start_i),
    .sweeps_i       (sweeps_i),
    .run_i          (run),
    .busy_i         (busy_o),
    .done_i         (done_o),
    .result_valid_i (result_valid_o),
    .spins_i        (spins_o),
    .magnet_i       (magnet_o)
);

//--- ising_core_tb.sv
////////////////////
// testbench for the ising core
// loads random couplings and flip masks, runs sweeps and compares the
// result with a software model of the sequential spin update
// inputs change 1 ns after the rising edge
////////////////////

`timescale 1ns/1ns

module ising_core_tb;

    localparam int NUM_SPIN   = ising_pkg::DEFAULT_NUM_SPIN;
    localparam int BIT_J      = ising_pkg::DEFAULT_BIT_J;
    localparam int FLIP_DEPTH = ising_pkg::DEFAULT_FLIP_DEPTH;
    localparam int ADDR_W     = $clog2(NUM_SPIN);
    localparam int CNT_W      = $clog2(NUM_SPIN + 1);
    localparam int ROW_W      = NUM_SPIN * BIT_J;

    logic                          clk, rst;
    logic                          wr_en, start;
    ising_pkg::mem_sel_e           wr_sel;
    logic [ADDR_W-1:0]             wr_addr;
    logic [ROW_W-1:0]              wr_data;
    logic [ising_pkg::SWEEP_W-1:0] sweeps;
    logic [NUM_SPIN-1:0]           init_spins;
    logic                          busy, done, result_valid;
    logic [NUM_SPIN-1:0]           spins;
    logic [CNT_W-1:0]              magnet;

    logic [ROW_W-1:0]    j_model [NUM_SPIN];     // host view of the J rows
    logic [NUM_SPIN-1:0] flip_model [FLIP_DEPTH];
    logic [15:0]         lfsr_q;

    tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) u_clock_gen (.clk_o(clk), .rst_o(rst));

    ising_core #(
        .NUM_SPIN   (NUM_SPIN),
        .BIT_J      (BIT_J),
        .FLIP_DEPTH (FLIP_DEPTH)
    ) ising_core_i (
        .clk_i          (clk),
        .rst_i          (rst),
        .wr_en_i        (wr_en),
        .wr_sel_i       (wr_sel),
        .wr_addr_i      (wr_addr),
        .wr_data_i      (wr_data),
        .start_i        (start),
        .sweeps_i       (sweeps),
        .init_spins_i   (init_spins),
        .busy_o         (busy),
        .done_o         (done),
        .result_valid_o (result_valid),
        .spins_o        (spins),
        .magnet_o       (magnet)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    always @(posedge clk) begin
        if (ising_core_i.u_asserts.assert_fail) begin
            stop_with_failure("a bound assertion on ising_core failed");
        end
    end

    ////////////////////
    // random source and reference model
    ////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v      = {v[30:0], lfsr_q[0]};  // one step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic int coupling(input logic [BIT_J-1:0] raw);
        int v;
        v = int'(raw);
        if (raw[BIT_J-1]) begin
            v = v - (1 << BIT_J);   // two's complement value
        end
        return v;
    endfunction

    function automatic logic [NUM_SPIN-1:0] expected_spins(input logic [NUM_SPIN-1:0] init,
                                                           input int n_sweeps);
        logic [NUM_SPIN-1:0] s;
        int field;
        int c;
        s = init;
        for (int k = 0; k < n_sweeps; k++) begin
            s = s ^ flip_model[k % FLIP_DEPTH];
            for (int i = 0; i < NUM_SPIN; i++) begin
                field = 0;
                for (int j = 0; j < NUM_SPIN; j++) begin
                    c     = coupling(j_model[i][j*BIT_J +: BIT_J]);
                    field = s[j] ? field + c : field - c;
                end
                s[i] = (field >= 0);    // latest values feed the next spin
            end
        end
        return s;
    endfunction

    ////////////////////
    // bus tasks
    ////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_mem(input ising_pkg::mem_sel_e sel, input int addr,
                             input logic [ROW_W-1:0] data);
        next_cycle();
        wr_en   = 1'b1;
        wr_sel  = sel;
        wr_addr = ADDR_W'(addr);
        wr_data = data;
        next_cycle();
        wr_en   = 1'b0;
    endtask

    task automatic load_j_row(input int row);
        logic [31:0] rnd;
        take_bits(ROW_W, rnd);
        j_model[row] = rnd[ROW_W-1:0];
        write_mem(ising_pkg::SEL_J, row, rnd[ROW_W-1:0]);
    endtask

    task automatic load_flip(input int idx, input logic zero);
        logic [31:0] rnd;
        take_bits(NUM_SPIN, rnd);
        if (zero) begin
            rnd = '0;
        end else if (rnd[NUM_SPIN-1:0] == '0) begin
            rnd[0] = 1'b1;  // keep every mask nonzero
        end
        flip_model[idx] = rnd[NUM_SPIN-1:0];
        write_mem(ising_pkg::SEL_FLIP, idx, ROW_W'(rnd[NUM_SPIN-1:0]));
    endtask

    task automatic random_spins(output logic [NUM_SPIN-1:0] s);
        logic [31:0] rnd;
        take_bits(NUM_SPIN, rnd);
        s = rnd[NUM_SPIN-1:0];
    endtask

    task automatic launch_run(input int n_sweeps, input logic [NUM_SPIN-1:0] s);
        next_cycle();
        start      = 1'b1;
        sweeps     = ising_pkg::SWEEP_W'(n_sweeps);
        init_spins = s;
        next_cycle();
        start      = 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!done) begin
            if (n >= limit) begin
                stop_with_failure("timeout while waiting for done_o");
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic check_result(input logic [NUM_SPIN-1:0] exp);
        logic [CNT_W-1:0] exp_cnt;
        exp_cnt = CNT_W'($countones(exp));
        assert (spins == exp) else stop_with_failure(
            $sformatf("error: spins_o expected 0x%0h got 0x%0h", exp, spins));
        assert (magnet == exp_cnt) else stop_with_failure(
            $sformatf("error: magnet_o expected 0x%0h got 0x%0h", exp_cnt, magnet));
    endtask

    task automatic run_and_check(input int n_sweeps, input logic [NUM_SPIN-1:0] s);
        logic [NUM_SPIN-1:0] exp;
        exp = expected_spins(s, n_sweeps);
        launch_run(n_sweeps, s);
        wait_done(n_sweeps * (2 * NUM_SPIN + 2) + 10);
        check_result(exp);
        repeat (3) next_cycle();    // idle gap, result must hold
    endtask

    // writes and a second start during a run must be dropped
    task automatic check_busy_lockout();
        logic [NUM_SPIN-1:0] s;
        logic [NUM_SPIN-1:0] exp;
        logic [31:0]         rnd;
        random_spins(s);
        exp = expected_spins(s, 3);
        launch_run(3, s);
        assert (busy) else stop_with_failure("busy_o not high right after start");
        for (int i = 0; i < 3; i++) begin
            take_bits(ROW_W, rnd);
            write_mem(ising_pkg::SEL_J, i, rnd[ROW_W-1:0]);
        end
        write_mem(ising_pkg::SEL_FLIP, 1, '1);
        launch_run(1, ~s);
        wait_done(3 * (2 * NUM_SPIN + 2) + 10);
        check_result(exp);
        repeat (3) next_cycle();
        random_spins(s);
        run_and_check(4, s);        // memories still hold the old contents
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst) begin
            if (n >= 10) begin
                stop_with_failure("reset was never released");
            end
            next_cycle();
            n++;
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        logic [NUM_SPIN-1:0] s;
        lfsr_q     = 16'd40;
        wr_en      = 1'b0;
        wr_sel     = ising_pkg::SEL_J;
        wr_addr    = '0;
        wr_data    = '0;
        start      = 1'b0;
        sweeps     = '0;
        init_spins = '0;
        wait_reset_release();

        for (int i = 0; i < NUM_SPIN; i++) begin
            load_j_row(i);
        end
        for (int k = 0; k < FLIP_DEPTH; k++) begin
            load_flip(k, 1'b1);
        end
        random_spins(s);
        run_and_check(3, s);

        // masks wrap around the table within 6 sweeps
        for (int k = 0; k < FLIP_DEPTH; k++) begin
            load_flip(k, 1'b0);
        end
        random_spins(s);
        run_and_check(6, s);

        random_spins(s);
        run_and_check(0, s);
        assert (spins == s) else stop_with_failure(
            $sformatf("error: spins_o expected 0x%0h got 0x%0h", s, spins));

        check_busy_lockout();
        repeat (4) next_cycle();

        if (ising_core_i.u_asserts.assert_fail) begin
            stop_with_failure("a bound assertion on ising_core failed");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- ising_core.f
ising_pkg.sv
ising_host_port.sv
ising_coupling_mem.sv
ising_spin_engine.sv
ising_readout.sv
ising_core.sv
tb_clock_gen.sv
ising_core_asserts.sv
ising_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the ising core testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ising_core_tb \
    -f ising_core.f -o ising_core_sim

# let bound assertion errors reach the testbench instead of stopping at once
if ./obj_dir/ising_core_sim +verilator+error+limit+100 | tee /dev/stderr \
        | grep -qx "Result: PASSED"; then
    echo "simulation ok"
else
    echo "simulation reported a failure"
    exit 1
fi
